// ==== rtl/core_pkg.sv ====
// pipeline widths and writeback source codes, imported by the stages and the register file
`default_nettype none

package core_pkg;

  // datapath and instruction widths
  localparam int xlen = 64;
  localparam int reg_addr_width = 5;
  localparam int inst_width = 32;

  // one-hot writeback source select
  localparam int wb_src_width = 3;
  localparam logic [wb_src_width-1:0] wb_src_ex  = 3'b001;
  localparam logic [wb_src_width-1:0] wb_src_mem = 3'b010;
  localparam logic [wb_src_width-1:0] wb_src_csr = 3'b100;

endpackage

`default_nettype wire

// ==== rtl/mem_pkg.sv ====
// memory operation and access size codes plus the console address, imported by the memory path
`default_nettype none

package mem_pkg;

  localparam int mem_op_width = 2;
  localparam logic [mem_op_width-1:0] mem_op_none  = 2'b00;
  localparam logic [mem_op_width-1:0] mem_op_load  = 2'b01;
  localparam logic [mem_op_width-1:0] mem_op_store = 2'b10;

  // access size in bytes is 1 << code
  localparam int mem_size_width = 2;
  localparam logic [mem_size_width-1:0] mem_size_byte  = 2'b00;
  localparam logic [mem_size_width-1:0] mem_size_half  = 2'b01;
  localparam logic [mem_size_width-1:0] mem_size_word  = 2'b10;
  localparam logic [mem_size_width-1:0] mem_size_dword = 2'b11;

  // stores here go to the serial port, not the RAM
  localparam logic [63:0] console_addr = 64'h0000_0000_1000_0000;

endpackage

`default_nettype wire

// ==== rtl/data_ram.sv ====
// data memory of 64-bit words for the memory stage, byte-lane write on the clock edge, async read
`timescale 1ns/100ps
`default_nettype none

module data_ram
  import core_pkg::*;
#(
  parameter int ram_depth = 256
) (
  input  wire logic                         clk,
  input  wire logic [$clog2(ram_depth)-1:0] ram_addr,
  input  wire logic                         ram_we,
  input  wire logic [xlen/8-1:0]            ram_be,
  input  wire logic [xlen-1:0]              ram_wdata,
  output logic      [xlen-1:0]              ram_rdata
);

  logic [xlen-1:0] mem [ram_depth];

  // one enable per byte lane
  always_ff @(posedge clk) begin
    if (ram_we) begin
      for (int i = 0; i < xlen / 8; i++) begin
        if (ram_be[i]) begin
          mem[ram_addr][8*i +: 8] <= ram_wdata[8*i +: 8];
        end
      end
    end
  end

  assign ram_rdata = mem[ram_addr];

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
// memory stage of the back end, holds one item, drives the data RAM and forms load and console data
`timescale 1ns/100ps
`default_nettype none

module mem_stage
  import core_pkg::*;
  import mem_pkg::*;
#(
  parameter int ram_depth = 256
) (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      ex_valid,
  input  wire logic [xlen-1:0]           ex_pc,
  input  wire logic [inst_width-1:0]     ex_inst,
  input  wire logic                      ex_wen,
  input  wire logic [reg_addr_width-1:0] ex_wdest,
  input  wire logic [wb_src_width-1:0]   ex_wb_src,
  input  wire logic [xlen-1:0]           ex_result,
  input  wire logic [xlen-1:0]           ex_csr_data,
  input  wire logic [mem_op_width-1:0]   ex_mem_op,
  input  wire logic [mem_size_width-1:0] ex_mem_size,
  input  wire logic                      ex_mem_unsigned,
  input  wire logic [xlen-1:0]           ex_store_data,
  input  wire logic                      wb_allowin,
  output logic                           mem_allowin,
  output logic                           mem_to_wb_valid,
  output logic [xlen-1:0]                mem_to_wb_pc,
  output logic [inst_width-1:0]          mem_to_wb_inst,
  output logic                           mem_to_wb_wen,
  output logic [reg_addr_width-1:0]      mem_to_wb_wdest,
  output logic [wb_src_width-1:0]        mem_to_wb_wb_src,
  output logic [xlen-1:0]                mem_to_wb_ex_result,
  output logic [xlen-1:0]                mem_to_wb_load_data,
  output logic [xlen-1:0]                mem_to_wb_csr_data,
  output logic                           mem_to_wb_console_valid,
  output logic [7:0]                     mem_to_wb_console_char
);

  localparam int addr_width = $clog2(ram_depth);

  logic                      mem_valid;
  logic [mem_op_width-1:0]   mem_op;
  logic [mem_size_width-1:0] mem_size;
  logic                      mem_unsigned;
  logic [xlen-1:0]           store_data;
  logic                      is_load;
  logic                      is_store;
  logic                      is_console;
  logic [2:0]                offset;
  logic [7:0]                size_mask;
  logic [xlen-1:0]           rd_shifted;
  logic [xlen-1:0]           load_ext;
  logic                      sext;
  logic [addr_width-1:0]     ram_addr;
  logic                      ram_we;
  logic [7:0]                ram_be;
  logic [xlen-1:0]           ram_wdata;
  logic [xlen-1:0]           ram_rdata;

  // never stalls while writeback takes every item
  assign mem_allowin = !mem_valid || wb_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid <= 1'b0;
    end else if (mem_allowin) begin
      mem_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid && mem_allowin) begin
      mem_to_wb_pc        <= ex_pc;
      mem_to_wb_inst      <= ex_inst;
      mem_to_wb_wen       <= ex_wen;
      mem_to_wb_wdest     <= ex_wdest;
      mem_to_wb_wb_src    <= ex_wb_src;
      mem_to_wb_ex_result <= ex_result;
      mem_to_wb_csr_data  <= ex_csr_data;
      mem_op              <= ex_mem_op;
      mem_size            <= ex_mem_size;
      mem_unsigned        <= ex_mem_unsigned;
      store_data          <= ex_store_data;
    end
  end

  always_comb begin
    is_load = 1'b0;
    is_store = 1'b0;
    case (mem_op)
      mem_op_load:  is_load = 1'b1;
      mem_op_store: is_store = 1'b1;
      mem_op_none:  ;
    endcase
  end

  // execute result carries the byte address
  assign offset = mem_to_wb_ex_result[2:0];
  assign ram_addr = mem_to_wb_ex_result[addr_width+2:3];
  assign is_console = mem_valid && is_store && (mem_to_wb_ex_result == console_addr);

  always_comb begin
    case (mem_size)
      mem_size_byte: size_mask = 8'h01;
      mem_size_half: size_mask = 8'h03;
      mem_size_word: size_mask = 8'h0f;
      default:       size_mask = 8'hff;
    endcase
  end

  assign ram_we = mem_valid && wb_allowin && is_store && !is_console;
  assign ram_be = size_mask << offset;
  assign ram_wdata = store_data << {offset, 3'b000};

  data_ram #(
    .ram_depth(ram_depth)
  ) data_ram_inst (
    .clk      (clk),
    .ram_addr (ram_addr),
    .ram_we   (ram_we),
    .ram_be   (ram_be),
    .ram_wdata(ram_wdata),
    .ram_rdata(ram_rdata)
  );

  // bring the addressed slice down to bit 0, then extend
  assign rd_shifted = ram_rdata >> {offset, 3'b000};
  assign sext = !mem_unsigned;

  always_comb begin
    case (mem_size)
      mem_size_byte:  load_ext = {{56{sext & rd_shifted[7]}}, rd_shifted[7:0]};
      mem_size_half:  load_ext = {{48{sext & rd_shifted[15]}}, rd_shifted[15:0]};
      mem_size_word:  load_ext = {{32{sext & rd_shifted[31]}}, rd_shifted[31:0]};
      mem_size_dword: load_ext = rd_shifted;
    endcase
  end

  assign mem_to_wb_valid = mem_valid;
  assign mem_to_wb_load_data = is_load ? load_ext : '0;
  assign mem_to_wb_console_valid = is_console;
  assign mem_to_wb_console_char = store_data[7:0];

endmodule

`default_nettype wire

// ==== rtl/wb_stage.sv ====
// writeback stage of the back end, picks the result, writes the register file and reports commits
`timescale 1ns/100ps
`default_nettype none

module wb_stage
  import core_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      mem_to_wb_valid,
  input  wire logic [xlen-1:0]           mem_to_wb_pc,
  input  wire logic [inst_width-1:0]     mem_to_wb_inst,
  input  wire logic                      mem_to_wb_wen,
  input  wire logic [reg_addr_width-1:0] mem_to_wb_wdest,
  input  wire logic [wb_src_width-1:0]   mem_to_wb_wb_src,
  input  wire logic [xlen-1:0]           mem_to_wb_ex_result,
  input  wire logic [xlen-1:0]           mem_to_wb_load_data,
  input  wire logic [xlen-1:0]           mem_to_wb_csr_data,
  input  wire logic                      mem_to_wb_console_valid,
  input  wire logic [7:0]                mem_to_wb_console_char,
  output logic                           wb_allowin,
  output logic                           reg_wr_ena,
  output logic [reg_addr_width-1:0]      reg_wr_addr,
  output logic [xlen-1:0]                reg_wr_data,
  output logic                           fwd_wen,
  output logic [reg_addr_width-1:0]      fwd_addr,
  output logic [xlen-1:0]                fwd_data,
  output logic                           commit_valid,
  output logic [xlen-1:0]                commit_pc,
  output logic [inst_width-1:0]          commit_inst,
  output logic                           uart_valid,
  output logic [7:0]                     uart_char
);

  logic                      wb_valid;
  logic [xlen-1:0]           wb_pc;
  logic [inst_width-1:0]     wb_inst;
  logic                      wb_wen;
  logic [reg_addr_width-1:0] wb_wdest;
  logic [wb_src_width-1:0]   wb_src;
  logic [xlen-1:0]           wb_ex_data;
  logic [xlen-1:0]           wb_load_data;
  logic [xlen-1:0]           wb_csr_data;
  logic                      wb_console;
  logic [7:0]                wb_char;
  logic                      ex_sel;
  logic                      mem_sel;
  logic                      csr_sel;

  // last stage, nothing downstream to wait on
  assign wb_allowin = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else if (wb_allowin) begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_to_wb_valid && wb_allowin) begin
      wb_pc        <= mem_to_wb_pc;
      wb_inst      <= mem_to_wb_inst;
      wb_wen       <= mem_to_wb_wen;
      wb_wdest     <= mem_to_wb_wdest;
      wb_src       <= mem_to_wb_wb_src;
      wb_ex_data   <= mem_to_wb_ex_result;
      wb_load_data <= mem_to_wb_load_data;
      wb_csr_data  <= mem_to_wb_csr_data;
      wb_console   <= mem_to_wb_console_valid;
      wb_char      <= mem_to_wb_console_char;
    end
  end

  // one-hot select, terms ORed together
  assign ex_sel  = wb_valid && |(wb_src & wb_src_ex);
  assign mem_sel = wb_valid && |(wb_src & wb_src_mem);
  assign csr_sel = wb_valid && |(wb_src & wb_src_csr);

  assign reg_wr_ena  = wb_valid && wb_wen;
  assign reg_wr_addr = wb_wdest & {reg_addr_width{wb_valid}};
  assign reg_wr_data = ({xlen{ex_sel}} & wb_ex_data)
                     | ({xlen{mem_sel}} & wb_load_data)
                     | ({xlen{csr_sel}} & wb_csr_data);

  // same write seen by the bypass network
  assign fwd_wen  = reg_wr_ena;
  assign fwd_addr = reg_wr_addr;
  assign fwd_data = reg_wr_data;

  assign commit_valid = wb_valid;
  assign commit_pc    = wb_pc & {xlen{wb_valid}};
  assign commit_inst  = wb_inst & {inst_width{wb_valid}};

  assign uart_valid = wb_valid && wb_console;
  assign uart_char  = wb_char & {8{uart_valid}};

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// general register file of the core, written by writeback, read by the top level read ports
`timescale 1ns/100ps
`default_nettype none

module regfile
  import core_pkg::*;
(
  input  wire logic                      clk,
  input  wire logic                      reg_wr_ena,
  input  wire logic [reg_addr_width-1:0] reg_wr_addr,
  input  wire logic [xlen-1:0]           reg_wr_data,
  input  wire logic [reg_addr_width-1:0] rs1_addr,
  input  wire logic [reg_addr_width-1:0] rs2_addr,
  output logic      [xlen-1:0]           rs1_data,
  output logic      [xlen-1:0]           rs2_data
);

  // x1..x31, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (reg_wr_ena && reg_wr_addr != '0) begin
      regs[reg_wr_addr] <= reg_wr_data;
    end
  end

  // async read, x0 reads zero
  always_comb begin
    rs1_data = '0;
    rs2_data = '0;
    if (rs1_addr != '0) begin
      rs1_data = regs[rs1_addr];
    end
    if (rs2_addr != '0) begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/back_end.sv ====
// top of the pipeline back end, joins memory stage, writeback stage and register file
`timescale 1ns/100ps
`default_nettype none

module back_end
  import core_pkg::*;
  import mem_pkg::*;
#(
  parameter int ram_depth = 256
) (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      ex_valid,
  input  wire logic [xlen-1:0]           ex_pc,
  input  wire logic [inst_width-1:0]     ex_inst,
  input  wire logic                      ex_wen,
  input  wire logic [reg_addr_width-1:0] ex_wdest,
  input  wire logic [wb_src_width-1:0]   ex_wb_src,
  input  wire logic [xlen-1:0]           ex_result,
  input  wire logic [xlen-1:0]           ex_csr_data,
  input  wire logic [mem_op_width-1:0]   ex_mem_op,
  input  wire logic [mem_size_width-1:0] ex_mem_size,
  input  wire logic                      ex_mem_unsigned,
  input  wire logic [xlen-1:0]           ex_store_data,
  input  wire logic [reg_addr_width-1:0] rs1_addr,
  input  wire logic [reg_addr_width-1:0] rs2_addr,
  output logic                           mem_allowin,
  output logic [xlen-1:0]                rs1_data,
  output logic [xlen-1:0]                rs2_data,
  output logic                           fwd_wen,
  output logic [reg_addr_width-1:0]      fwd_addr,
  output logic [xlen-1:0]                fwd_data,
  output logic                           commit_valid,
  output logic [xlen-1:0]                commit_pc,
  output logic [inst_width-1:0]          commit_inst,
  output logic                           uart_valid,
  output logic [7:0]                     uart_char
);

  logic                      wb_allowin;
  logic                      mem_to_wb_valid;
  logic [xlen-1:0]           mem_to_wb_pc;
  logic [inst_width-1:0]     mem_to_wb_inst;
  logic                      mem_to_wb_wen;
  logic [reg_addr_width-1:0] mem_to_wb_wdest;
  logic [wb_src_width-1:0]   mem_to_wb_wb_src;
  logic [xlen-1:0]           mem_to_wb_ex_result;
  logic [xlen-1:0]           mem_to_wb_load_data;
  logic [xlen-1:0]           mem_to_wb_csr_data;
  logic                      mem_to_wb_console_valid;
  logic [7:0]                mem_to_wb_console_char;
  logic                      reg_wr_ena;
  logic [reg_addr_width-1:0] reg_wr_addr;
  logic [xlen-1:0]           reg_wr_data;

  mem_stage #(
    .ram_depth(ram_depth)
  ) mem_stage_inst (
    .clk                    (clk),
    .rst                    (rst),
    .ex_valid               (ex_valid),
    .ex_pc                  (ex_pc),
    .ex_inst                (ex_inst),
    .ex_wen                 (ex_wen),
    .ex_wdest               (ex_wdest),
    .ex_wb_src              (ex_wb_src),
    .ex_result              (ex_result),
    .ex_csr_data            (ex_csr_data),
    .ex_mem_op              (ex_mem_op),
    .ex_mem_size            (ex_mem_size),
    .ex_mem_unsigned        (ex_mem_unsigned),
    .ex_store_data          (ex_store_data),
    .wb_allowin             (wb_allowin),
    .mem_allowin            (mem_allowin),
    .mem_to_wb_valid        (mem_to_wb_valid),
    .mem_to_wb_pc           (mem_to_wb_pc),
    .mem_to_wb_inst         (mem_to_wb_inst),
    .mem_to_wb_wen          (mem_to_wb_wen),
    .mem_to_wb_wdest        (mem_to_wb_wdest),
    .mem_to_wb_wb_src       (mem_to_wb_wb_src),
    .mem_to_wb_ex_result    (mem_to_wb_ex_result),
    .mem_to_wb_load_data    (mem_to_wb_load_data),
    .mem_to_wb_csr_data     (mem_to_wb_csr_data),
    .mem_to_wb_console_valid(mem_to_wb_console_valid),
    .mem_to_wb_console_char (mem_to_wb_console_char)
  );

  wb_stage wb_stage_inst (
    .clk                    (clk),
    .rst                    (rst),
    .mem_to_wb_valid        (mem_to_wb_valid),
    .mem_to_wb_pc           (mem_to_wb_pc),
    .mem_to_wb_inst         (mem_to_wb_inst),
    .mem_to_wb_wen          (mem_to_wb_wen),
    .mem_to_wb_wdest        (mem_to_wb_wdest),
    .mem_to_wb_wb_src       (mem_to_wb_wb_src),
    .mem_to_wb_ex_result    (mem_to_wb_ex_result),
    .mem_to_wb_load_data    (mem_to_wb_load_data),
    .mem_to_wb_csr_data     (mem_to_wb_csr_data),
    .mem_to_wb_console_valid(mem_to_wb_console_valid),
    .mem_to_wb_console_char (mem_to_wb_console_char),
    .wb_allowin             (wb_allowin),
    .reg_wr_ena             (reg_wr_ena),
    .reg_wr_addr            (reg_wr_addr),
    .reg_wr_data            (reg_wr_data),
    .fwd_wen                (fwd_wen),
    .fwd_addr               (fwd_addr),
    .fwd_data               (fwd_data),
    .commit_valid           (commit_valid),
    .commit_pc              (commit_pc),
    .commit_inst            (commit_inst),
    .uart_valid             (uart_valid),
    .uart_char              (uart_char)
  );

  regfile regfile_inst (
    .clk        (clk),
    .reg_wr_ena (reg_wr_ena),
    .reg_wr_addr(reg_wr_addr),
    .reg_wr_data(reg_wr_data),
    .rs1_addr   (rs1_addr),
    .rs2_addr   (rs2_addr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data)
  );

endmodule

`default_nettype wire

// ==== bench/back_end_sva.sv ====
// concurrent checks on the back end handshake, reset and console outputs, bound into back_end
`timescale 1ns/100ps
`default_nettype none

module back_end_sva (
  input wire logic clk,
  input wire logic rst,
  input wire logic mem_allowin,
  input wire logic commit_valid,
  input wire logic fwd_wen,
  input wire logic uart_valid,
  input wire logic reg_wr_ena
);

  // reports go quiet one edge after reset is seen
  reset_quiet: assert property (
    @(posedge clk) rst |=> (!commit_valid && !fwd_wen && !uart_valid && !reg_wr_ena)
  ) else $error("report outputs active after a reset edge");

  // writeback never stalls
  allowin_high: assert property (
    @(posedge clk) disable iff (rst) mem_allowin
  ) else $error("mem_allowin low outside reset");

  uart_with_commit: assert property (
    @(posedge clk) disable iff (rst) uart_valid |-> commit_valid
  ) else $error("uart_valid high without commit_valid");

  // forward report mirrors the register write
  write_forwarded: assert property (
    @(posedge clk) reg_wr_ena |-> fwd_wen
  ) else $error("reg_wr_ena high while fwd_wen low");

endmodule

bind back_end back_end_sva back_end_sva_inst (
  .clk         (clk),
  .rst         (rst),
  .mem_allowin (mem_allowin),
  .commit_valid(commit_valid),
  .fwd_wen     (fwd_wen),
  .uart_valid  (uart_valid),
  .reg_wr_ena  (reg_wr_ena)
);

`default_nettype wire

// ==== bench/back_end_tb.sv ====
// testbench for the back end, drives execute items against a shadow model checked every cycle
`timescale 1ns/100ps
`default_nettype none

module back_end_tb
  import core_pkg::*;
  import mem_pkg::*;
();

  localparam int ram_depth = 256;
  localparam int ram_bytes = ram_depth * 8;
  localparam int clk_period = 100;
  localparam int n_alu = 40;
  localparam int n_x0 = 4;
  localparam int n_fill = 16;
  localparam int n_mem = 30;
  localparam int n_console = 3;
  localparam int n_order = 30;
  localparam int n_flush = 5;
  // items, gaps of up to two cycles, then room for sweeps and drains
  localparam int watchdog_cycles = n_alu + n_x0 + n_fill + 2 * n_mem + 2 * n_console
                                 + 3 * n_order + n_flush + 300;
  localparam logic [xlen-1:0] console_word = ((console_addr >> 3) % ram_depth) * 8;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      ex_valid;
  logic [xlen-1:0]           ex_pc;
  logic [inst_width-1:0]     ex_inst;
  logic                      ex_wen;
  logic [reg_addr_width-1:0] ex_wdest;
  logic [wb_src_width-1:0]   ex_wb_src;
  logic [xlen-1:0]           ex_result;
  logic [xlen-1:0]           ex_csr_data;
  logic [mem_op_width-1:0]   ex_mem_op;
  logic [mem_size_width-1:0] ex_mem_size;
  logic                      ex_mem_unsigned;
  logic [xlen-1:0]           ex_store_data;
  logic [reg_addr_width-1:0] rs1_addr;
  logic [reg_addr_width-1:0] rs2_addr;
  logic                      mem_allowin;
  logic [xlen-1:0]           rs1_data;
  logic [xlen-1:0]           rs2_data;
  logic                      fwd_wen;
  logic [reg_addr_width-1:0] fwd_addr;
  logic [xlen-1:0]           fwd_data;
  logic                      commit_valid;
  logic [xlen-1:0]           commit_pc;
  logic [inst_width-1:0]     commit_inst;
  logic                      uart_valid;
  logic [7:0]                uart_char;

  integer          seed;
  int              check_count;
  int              error_count;
  logic [xlen-1:0] next_pc;
  logic [xlen-1:0] load_val;
  logic [xlen-1:0] sel_data;
  logic [mem_size_width-1:0] size;

  // shadow state
  logic [xlen-1:0] sh_regs [32];
  logic            sh_known [32];
  logic [7:0]      sh_mem [ram_bytes];

  // expected contents of the memory and writeback stages
  logic                      m_mem_v;
  logic [xlen-1:0]           m_mem_pc;
  logic [inst_width-1:0]     m_mem_inst;
  logic                      m_mem_wen;
  logic [reg_addr_width-1:0] m_mem_wdest;
  logic [wb_src_width-1:0]   m_mem_src;
  logic [xlen-1:0]           m_mem_result;
  logic [xlen-1:0]           m_mem_csr;
  logic [mem_op_width-1:0]   m_mem_op;
  logic [mem_size_width-1:0] m_mem_size;
  logic                      m_mem_uns;
  logic [xlen-1:0]           m_mem_sdata;
  logic                      m_wb_v;
  logic [xlen-1:0]           m_wb_pc;
  logic [inst_width-1:0]     m_wb_inst;
  logic                      m_wb_wen;
  logic [reg_addr_width-1:0] m_wb_wdest;
  logic [xlen-1:0]           m_wb_data;
  logic                      m_wb_uart;
  logic [7:0]                m_wb_char;

  back_end #(
    .ram_depth(ram_depth)
  ) back_end_inst (.*);

  always #(clk_period / 2) clk = ~clk;

  task automatic check_value(input string name, input logic [xlen-1:0] got,
                             input logic [xlen-1:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_read(input string name, input logic [reg_addr_width-1:0] addr,
                            input logic [xlen-1:0] data);
    if (addr == 0) begin
      check_value(name, data, '0);
    end else if (sh_known[addr]) begin
      check_value(name, data, sh_regs[addr]);
    end
  endtask

  function automatic logic [xlen-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // aligned byte address inside the filled words
  function automatic logic [xlen-1:0] rand_addr(input logic [mem_size_width-1:0] sz);
    logic [xlen-1:0] a;
    a = {$random(seed)} % (n_fill * 8);
    return a & ~((64'd1 << sz) - 1);
  endfunction

  // little-endian slice, sign taken from the top loaded byte
  function automatic logic [xlen-1:0] load_result(input logic [xlen-1:0] addr,
                                                  input logic [mem_size_width-1:0] sz,
                                                  input logic uns);
    logic [xlen-1:0] v;
    int n;
    n = 1 << sz;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = sh_mem[(addr + i) % ram_bytes];
    end
    if (!uns && n < 8 && v[8*n-1]) begin
      v = v | (~64'd0 << (8 * n));
    end
    return v;
  endfunction

  always @(negedge clk) begin
    check_value("commit_valid", commit_valid, m_wb_v);
    check_value("fwd_wen", fwd_wen, m_wb_v && m_wb_wen);
    check_value("reg_wr_ena", back_end_inst.reg_wr_ena, m_wb_v && m_wb_wen);
    check_value("uart_valid", uart_valid, m_wb_v && m_wb_uart);
    if (m_wb_v) begin
      check_value("commit_pc", commit_pc, m_wb_pc);
      check_value("commit_inst", commit_inst, m_wb_inst);
    end
    if (m_wb_v && m_wb_wen) begin
      check_value("fwd_addr", fwd_addr, m_wb_wdest);
      check_value("fwd_data", fwd_data, m_wb_data);
    end
    if (m_wb_v && m_wb_uart) begin
      check_value("uart_char", uart_char, m_wb_char);
    end
    if (!rst) begin
      check_value("mem_allowin", mem_allowin, 1'b1);
    end
    check_read("rs1_data", rs1_addr, rs1_data);
    check_read("rs2_data", rs2_addr, rs2_data);
    // effects of the coming edge
    if (m_wb_v && m_wb_wen && m_wb_wdest != 0) begin
      sh_regs[m_wb_wdest] = m_wb_data;
      sh_known[m_wb_wdest] = 1'b1;
    end
    load_val = '0;
    if (m_mem_v && m_mem_op == mem_op_load) begin
      load_val = load_result(m_mem_result, m_mem_size, m_mem_uns);
    end
    if (m_mem_v && m_mem_op == mem_op_store && m_mem_result != console_addr) begin
      for (int i = 0; i < (1 << m_mem_size); i++) begin
        sh_mem[(m_mem_result + i) % ram_bytes] = m_mem_sdata[8*i +: 8];
      end
    end
    sel_data = '0;
    if ((m_mem_src & wb_src_ex) != 0) sel_data = sel_data | m_mem_result;
    if ((m_mem_src & wb_src_mem) != 0) sel_data = sel_data | load_val;
    if ((m_mem_src & wb_src_csr) != 0) sel_data = sel_data | m_mem_csr;
    m_wb_v = !rst && m_mem_v;
    if (m_mem_v) begin
      m_wb_pc = m_mem_pc;
      m_wb_inst = m_mem_inst;
      m_wb_wen = m_mem_wen;
      m_wb_wdest = m_mem_wdest;
      m_wb_data = sel_data;
      m_wb_uart = m_mem_op == mem_op_store && m_mem_result == console_addr;
      m_wb_char = m_mem_sdata[7:0];
    end
    m_mem_v = !rst && ex_valid && mem_allowin;
    if (ex_valid) begin
      m_mem_pc = ex_pc;
      m_mem_inst = ex_inst;
      m_mem_wen = ex_wen;
      m_mem_wdest = ex_wdest;
      m_mem_src = ex_wb_src;
      m_mem_result = ex_result;
      m_mem_csr = ex_csr_data;
      m_mem_op = ex_mem_op;
      m_mem_size = ex_mem_size;
      m_mem_uns = ex_mem_unsigned;
      m_mem_sdata = ex_store_data;
    end
  end

  task automatic issue_item(input logic [wb_src_width-1:0] src, input logic wen,
                            input logic [reg_addr_width-1:0] wdest,
                            input logic [xlen-1:0] result, input logic [mem_op_width-1:0] op,
                            input logic [mem_size_width-1:0] sz, input logic uns,
                            input logic [xlen-1:0] sdata);
    @(posedge clk);
    ex_valid <= 1'b1;
    ex_pc <= next_pc;
    ex_inst <= $random(seed);
    ex_wen <= wen;
    ex_wdest <= wdest;
    ex_wb_src <= src;
    ex_result <= result;
    ex_csr_data <= rand64();
    ex_mem_op <= op;
    ex_mem_size <= sz;
    ex_mem_unsigned <= uns;
    ex_store_data <= sdata;
    rs1_addr <= $random(seed);
    rs2_addr <= wdest;
    next_pc = next_pc + 4;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      ex_valid <= 1'b0;
    end
  endtask

  task automatic wait_drain();
    idle_cycles(1);
    do @(posedge clk); while (m_mem_v || m_wb_v);
  endtask

  task automatic sweep_regs();
    for (int i = 0; i < 32; i++) begin
      @(posedge clk);
      ex_valid <= 1'b0;
      rs1_addr <= i;
      rs2_addr <= 31 - i;
    end
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    rst <= 1'b1;
    ex_valid <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("Testbench failed");
    $finish;
  end

  initial begin
    seed = 32'h4ff86c4a;
    check_count = 0;
    error_count = 0;
    next_pc = 64'h8000_0000;
    m_mem_v = 1'b0;
    m_wb_v = 1'b0;
    for (int i = 0; i < 32; i++) begin
      sh_known[i] = 1'b0;
    end
    rst = 1'b1;
    ex_valid = 1'b0;
    ex_pc = '0;
    ex_inst = '0;
    ex_wen = 1'b0;
    ex_wdest = '0;
    ex_wb_src = wb_src_ex;
    ex_result = '0;
    ex_csr_data = '0;
    ex_mem_op = mem_op_none;
    ex_mem_size = mem_size_dword;
    ex_mem_unsigned = 1'b0;
    ex_store_data = '0;
    rs1_addr = '0;
    rs2_addr = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // execute and csr results
    for (int i = 0; i < n_alu; i++) begin
      issue_item(($random(seed) & 1) ? wb_src_csr : wb_src_ex, 1'b1, 1 + {$random(seed)} % 31,
                 rand64(), mem_op_none, mem_size_dword, 1'b0, '0);
    end
    wait_drain();
    sweep_regs();
    // x0 stays zero
    for (int i = 0; i < n_x0; i++) begin
      issue_item(wb_src_ex, 1'b1, '0, rand64(), mem_op_none, mem_size_dword, 1'b0, '0);
    end
    wait_drain();
    // fill the test words, then mixed stores and loads
    for (int i = 0; i < n_fill; i++) begin
      issue_item(wb_src_ex, 1'b0, '0, i * 8, mem_op_store, mem_size_dword, 1'b0, rand64());
    end
    for (int i = 0; i < n_mem; i++) begin
      size = $random(seed);
      issue_item(wb_src_ex, 1'b0, '0, rand_addr(size), mem_op_store, size, 1'b0, rand64());
    end
    for (int i = 0; i < n_mem; i++) begin
      size = $random(seed);
      issue_item(wb_src_mem, 1'b1, 1 + {$random(seed)} % 31, rand_addr(size), mem_op_load,
                 size, $random(seed), '0);
    end
    wait_drain();
    sweep_regs();
    // console stores leave the ram word alone
    for (int i = 0; i < n_console; i++) begin
      issue_item(wb_src_ex, 1'b0, '0, console_addr, mem_op_store, mem_size_byte, 1'b0, rand64());
      issue_item(wb_src_mem, 1'b1, 1 + i, console_word, mem_op_load, mem_size_dword, 1'b1, '0);
    end
    wait_drain();
    // commit order with gaps
    for (int i = 0; i < n_order; i++) begin
      issue_item(wb_src_ex, 1'b1, 1 + {$random(seed)} % 31, rand64(), mem_op_none,
                 mem_size_dword, 1'b0, '0);
      idle_cycles({$random(seed)} % 3);
    end
    wait_drain();
    // reset with items in flight
    for (int i = 0; i < n_flush; i++) begin
      issue_item(wb_src_csr, 1'b1, 1 + {$random(seed)} % 31, rand64(), mem_op_none,
                 mem_size_dword, 1'b0, '0);
    end
    pulse_reset();
    sweep_regs();
    wait_drain();

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/core_pkg.sv
rtl/mem_pkg.sv
rtl/data_ram.sv
rtl/mem_stage.sv
rtl/wb_stage.sv
rtl/regfile.sv
rtl/back_end.sv
bench/back_end_sva.sv
bench/back_end_tb.sv

// ==== Bender.yml ====
package:
  name: back_end

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/mem_pkg.sv
      - rtl/data_ram.sv
      - rtl/mem_stage.sv
      - rtl/wb_stage.sv
      - rtl/regfile.sv
      - rtl/back_end.sv
  - target: simulation
    files:
      - bench/back_end_sva.sv
      - bench/back_end_tb.sv
